//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = conv_layer_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
source/cnn_pkg.sv
source/line_3_buffer.sv
source/conv3x3_row_engine.sv
source/conv_layer_top.sv
verification/clock_reset_gen.sv
verification/conv_layer_tb.sv

//--- source/cnn_pkg.sv
package cnn_pkg;

    // layer dimensions.
    localparam int PIXEL_BITS   = 8;
    localparam int ROW_WIDTH    = 8;
    localparam int IMAGE_HEIGHT = 8;
    localparam int CHANNELS     = 2;
    localparam int ACC_BITS     = 20;
    localparam int WEIGHT_BITS  = 4;
    localparam int OUT_SHIFT    = 3;

    localparam int PIXEL_MAX        = (1 << PIXEL_BITS) - 1;
    localparam int PADDED_WIDTH     = ROW_WIDTH + 2;   // one zero pixel on each side.
    localparam int CHAN_BITS        = ROW_WIDTH * PIXEL_BITS;
    localparam int PADDED_CHAN_BITS = PADDED_WIDTH * PIXEL_BITS;

    typedef logic [PIXEL_BITS-1:0] pixel_t;
    typedef logic signed [WEIGHT_BITS-1:0] weight_t;
    typedef logic signed [ACC_BITS-1:0] acc_t;
    typedef logic [$clog2(IMAGE_HEIGHT+1)-1:0] row_count_t;

    // Channel c, pixel x sits at bit (c*ROW_WIDTH + x)*PIXEL_BITS.
    typedef logic [CHANNELS*CHAN_BITS-1:0] row_t;

    // Channel c, padded pixel x sits at bit (c*PADDED_WIDTH + x)*PIXEL_BITS,
    // x = 0 and x = ROW_WIDTH+1 hold the zero padding.
    typedef logic [CHANNELS*PADDED_CHAN_BITS-1:0] padded_row_t;

    typedef struct packed {
        padded_row_t top;
        padded_row_t middle;
        padded_row_t bottom;
    } row_window_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } engine_state_t;

    // kernel index order is channel, kernel row (top first), kernel column (left first).
    localparam weight_t KERNEL [CHANNELS][3][3] = '{
        '{
            '{ 4'sd1,  4'sd2,  4'sd1},
            '{ 4'sd2,  4'sd4,  4'sd2},
            '{ 4'sd1,  4'sd2,  4'sd1}
        },
        '{
            '{-4'sd1, -4'sd2, -4'sd1},
            '{-4'sd2,  4'sd7, -4'sd2},
            '{-4'sd1, -4'sd2, -4'sd1}
        }
    };

endpackage

//--- source/conv3x3_row_engine.sv
`timescale 1ns/1ns

module conv3x3_row_engine (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     window_valid_i,
    input  cnn_pkg::row_window_t     window_i,
    output logic                     pixel_valid_o,
    output cnn_pkg::pixel_t          pixel_o,
    output logic                     row_done_o
);

    cnn_pkg::engine_state_t state;
    cnn_pkg::row_window_t   window_q;
    cnn_pkg::acc_t          acc;
    cnn_pkg::acc_t          shifted;
    cnn_pkg::pixel_t        next_pixel;
    logic [$clog2(cnn_pkg::ROW_WIDTH)-1:0] col;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state         <= cnn_pkg::IDLE;
            col           <= '0;
            pixel_valid_o <= 1'b0;
        end else begin
            pixel_valid_o <= (state == cnn_pkg::RUN);
            case (state)
                cnn_pkg::IDLE: begin
                    if (window_valid_i) begin
                        state <= cnn_pkg::RUN;
                        col   <= '0;
                    end
                end
                cnn_pkg::RUN: begin
                    if (int'(col) == cnn_pkg::ROW_WIDTH - 1) begin
                        state <= cnn_pkg::FINISH;
                    end
                    col <= col + 1'b1;
                end
                cnn_pkg::FINISH: begin
                    state <= cnn_pkg::IDLE;
                end
                default: begin
                    state <= cnn_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == cnn_pkg::IDLE) && window_valid_i) begin
            window_q <= window_i;
        end
        if (state == cnn_pkg::RUN) begin
            pixel_o <= next_pixel;
        end
    end

    // FINISH lines up with the last pixel on the output register.
    assign row_done_o = (state == cnn_pkg::FINISH);

    // 3x3 multiply-accumulate over both channels for the current column.
    always_comb begin
        cnn_pkg::padded_row_t rows [3];
        cnn_pkg::pixel_t      pix;
        int                   base;
        rows[0] = window_q.top;
        rows[1] = window_q.middle;
        rows[2] = window_q.bottom;
        acc     = '0;
        for (int c = 0; c < cnn_pkg::CHANNELS; c++) begin
            for (int ky = 0; ky < 3; ky++) begin
                for (int kx = 0; kx < 3; kx++) begin
                    base = (c*cnn_pkg::PADDED_WIDTH + int'(col) + kx) * cnn_pkg::PIXEL_BITS;
                    pix  = rows[ky][base +: cnn_pkg::PIXEL_BITS];
                    acc  = acc + cnn_pkg::acc_t'($signed({1'b0, pix})) *
                                 cnn_pkg::acc_t'(cnn_pkg::KERNEL[c][ky][kx]);
                end
            end
        end
    end

    always_comb begin
        shifted = acc >>> cnn_pkg::OUT_SHIFT;
        if (acc < 0) begin
            next_pixel = '0;   // relu.
        end else if (shifted > cnn_pkg::acc_t'(cnn_pkg::PIXEL_MAX)) begin
            next_pixel = cnn_pkg::pixel_t'(cnn_pkg::PIXEL_MAX);
        end else begin
            next_pixel = shifted[cnn_pkg::PIXEL_BITS-1:0];
        end
    end

    // the buffer must not offer a window while a row is being processed.
    a_window_in_idle : assert property (
        @(posedge clk) disable iff (!resetn)
        window_valid_i |-> (state == cnn_pkg::IDLE)
    ) else $error("conv3x3_row_engine: window strobe outside IDLE");

    a_valid_ends_with_row : assert property (
        @(posedge clk) disable iff (!resetn)
        $fell(pixel_valid_o) == $past(row_done_o)
    ) else $error("conv3x3_row_engine: pixel_valid_o did not fall right after row_done_o");

endmodule

//--- source/conv_layer_top.sv
`timescale 1ns/1ns

module conv_layer_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                row_valid_i,
    input  cnn_pkg::row_t       row_data_i,
    output logic                pixel_valid_o,
    output cnn_pkg::pixel_t     pixel_o,
    output logic                row_done_o
);

    logic                 window_valid;
    cnn_pkg::row_window_t window;
    logic                 row_done;

    line_3_buffer u_line_buffer (
        .clk            (clk),
        .resetn         (resetn),
        .row_valid_i    (row_valid_i),
        .row_data_i     (row_data_i),
        .row_done_i     (row_done),
        .window_valid_o (window_valid),
        .window_o       (window)
    );

    // one output row per window, row_done feeds back to release the bottom padding.
    conv3x3_row_engine u_row_engine (
        .clk            (clk),
        .resetn         (resetn),
        .window_valid_i (window_valid),
        .window_i       (window),
        .pixel_valid_o  (pixel_valid_o),
        .pixel_o        (pixel_o),
        .row_done_o     (row_done)
    );

    assign row_done_o = row_done;

endmodule

//--- source/line_3_buffer.sv
`timescale 1ns/1ns

module line_3_buffer (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     row_valid_i,
    input  cnn_pkg::row_t            row_data_i,
    input  logic                     row_done_i,
    output logic                     window_valid_o,
    output cnn_pkg::row_window_t     window_o
);

    cnn_pkg::padded_row_t slot [3];
    cnn_pkg::padded_row_t padded_in;
    cnn_pkg::row_count_t  row_count;
    logic [1:0]           wr_ptr;      // points at the oldest slot.
    logic [1:0]           ptr_mid;
    logic [1:0]           ptr_new;
    logic [1:0]           fill_count;
    logic                 pad_event;
    logic                 tail_busy;   // bottom padding window still in the engine.

    function automatic logic [1:0] next_slot(input logic [1:0] p);
        return (p == 2'd2) ? 2'd0 : p + 2'd1;
    endfunction

    assign ptr_mid = next_slot(wr_ptr);
    assign ptr_new = next_slot(ptr_mid);

    // The last image row's window is done, so the bottom zero row goes in now.
    assign pad_event = row_done_i &&
                       (row_count == cnn_pkg::row_count_t'(cnn_pkg::IMAGE_HEIGHT));

    always_comb begin
        padded_in = '0;
        for (int c = 0; c < cnn_pkg::CHANNELS; c++) begin
            padded_in[c*cnn_pkg::PADDED_CHAN_BITS + cnn_pkg::PIXEL_BITS +: cnn_pkg::CHAN_BITS] =
                row_data_i[c*cnn_pkg::CHAN_BITS +: cnn_pkg::CHAN_BITS];
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 3; i++) begin
                slot[i] <= '0;
            end
        end else if (row_valid_i) begin
            slot[wr_ptr] <= padded_in;
        end else if (pad_event) begin
            slot[wr_ptr] <= '0;   // oldest row becomes the bottom padding.
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr         <= 2'd0;
            fill_count     <= 2'd0;
            row_count      <= '0;
            window_valid_o <= 1'b0;
            tail_busy      <= 1'b0;
        end else begin
            window_valid_o <= (row_valid_i && (fill_count != 2'd0)) || pad_event;
            if (row_valid_i) begin
                wr_ptr    <= ptr_mid;
                row_count <= row_count + 1'b1;
                if (fill_count != 2'd2) begin
                    fill_count <= fill_count + 2'd1;
                end
            end else if (pad_event) begin
                // the slot after the zeroed one is where the next frame starts.
                wr_ptr     <= ptr_mid;
                row_count  <= '0;
                fill_count <= 2'd0;
            end
            if (pad_event) begin
                tail_busy <= 1'b1;
            end else if (row_done_i) begin
                tail_busy <= 1'b0;
            end
        end
    end

    assign window_o.top    = slot[wr_ptr];
    assign window_o.middle = slot[ptr_mid];
    assign window_o.bottom = slot[ptr_new];

    // the source must hold off from the last image row until the padding window is done.
    a_no_row_during_tail : assert property (
        @(posedge clk) disable iff (!resetn)
        row_valid_i |->
            (row_count != cnn_pkg::row_count_t'(cnn_pkg::IMAGE_HEIGHT)) && !tail_busy
    ) else $error("line_3_buffer: row received while bottom padding is pending");

endmodule

//--- verification/clock_reset_gen.sv
`timescale 1ns/1ns

module clock_reset_gen (
    output logic clk_o,
    output logic resetn_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;   // 20 ns period.
        end
    end

    initial begin
        resetn_o = 1'b0;
        repeat (16) begin
            @(posedge clk_o);
        end
        @(negedge clk_o);
        resetn_o = 1'b1;   // release half a cycle away from the rising edge.
    end

endmodule

//--- verification/conv_layer_tb.sv
`timescale 1ns/1ns

module conv_layer_tb;

    logic            clk;
    logic            resetn;
    logic            row_valid;
    cnn_pkg::row_t   row_data;
    logic            pixel_valid;
    cnn_pkg::pixel_t pixel;
    logic            row_done;

    cnn_pkg::pixel_t image [cnn_pkg::CHANNELS][cnn_pkg::IMAGE_HEIGHT][cnn_pkg::ROW_WIDTH];
    cnn_pkg::pixel_t expected_q [$];
    cnn_pkg::pixel_t expected_head;
    logic            head_valid;
    logic            pop_pending;
    logic            row_closed;
    logic [15:0]     lfsr_state;
    logic            launch;
    int              row_index;
    int              pix_in_row;
    int              done_total;
    int              cycle_count;
    int              error_count;
    int              assert_count;

    clock_reset_gen clock_gen (
        .clk_o    (clk),
        .resetn_o (resetn)
    );

    conv_layer_top UUT (
        .clk           (clk),
        .resetn        (resetn),
        .row_valid_i   (row_valid),
        .row_data_i    (row_data),
        .pixel_valid_o (pixel_valid),
        .pixel_o       (pixel),
        .row_done_o    (row_done)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic draw_pixel(output cnn_pkg::pixel_t p);
        for (int b = 0; b < cnn_pkg::PIXEL_BITS; b++) begin
            p[b]       = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic fill_frame(input int frame);
        cnn_pkg::pixel_t p;
        for (int c = 0; c < cnn_pkg::CHANNELS; c++) begin
            for (int y = 0; y < cnn_pkg::IMAGE_HEIGHT; y++) begin
                for (int x = 0; x < cnn_pkg::ROW_WIDTH; x++) begin
                    if (frame == 0) begin
                        draw_pixel(p);
                    end else if (frame == 1) begin
                        p = cnn_pkg::pixel_t'(cnn_pkg::PIXEL_MAX);
                    end else begin
                        p = '0;
                    end
                    image[c][y][x] = p;
                end
            end
        end
    endtask

    // pixels outside the image read as zero, which gives the padding.
    function automatic cnn_pkg::pixel_t model_pixel(input int r, input int x);
        int acc;
        int yy;
        int xx;
        acc = 0;
        for (int c = 0; c < cnn_pkg::CHANNELS; c++) begin
            for (int ky = 0; ky < 3; ky++) begin
                for (int kx = 0; kx < 3; kx++) begin
                    yy = r - 1 + ky;
                    xx = x - 1 + kx;
                    if (yy >= 0 && yy < cnn_pkg::IMAGE_HEIGHT &&
                        xx >= 0 && xx < cnn_pkg::ROW_WIDTH) begin
                        acc = acc + int'(image[c][yy][xx]) * int'(cnn_pkg::KERNEL[c][ky][kx]);
                    end
                end
            end
        end
        if (acc < 0) begin
            return '0;
        end
        acc = acc >> cnn_pkg::OUT_SHIFT;
        if (acc > cnn_pkg::PIXEL_MAX) begin
            return cnn_pkg::pixel_t'(cnn_pkg::PIXEL_MAX);
        end
        return cnn_pkg::pixel_t'(acc);
    endfunction

    task automatic queue_expected();
        for (int r = 0; r < cnn_pkg::IMAGE_HEIGHT; r++) begin
            for (int x = 0; x < cnn_pkg::ROW_WIDTH; x++) begin
                expected_q.push_back(model_pixel(r, x));
            end
        end
    endtask

    task automatic send_row(input int r);
        cnn_pkg::row_t data;
        data = '0;
        for (int c = 0; c < cnn_pkg::CHANNELS; c++) begin
            for (int x = 0; x < cnn_pkg::ROW_WIDTH; x++) begin
                data[(c*cnn_pkg::ROW_WIDTH + x)*cnn_pkg::PIXEL_BITS +: cnn_pkg::PIXEL_BITS] =
                    image[c][r][x];
            end
        end
        row_data  = data;
        row_valid = 1'b1;
        row_index = r + 1;
        @(negedge clk);
        row_valid = 1'b0;
    endtask

    task automatic wait_row_done();
        @(negedge clk);
        while (!row_done) begin
            @(negedge clk);
        end
    endtask

    // a window leaves the buffer for row 2 onward and for the padding after the last row.
    assign launch = (row_valid && row_index >= 2) ||
                    (row_done && (done_total % cnn_pkg::IMAGE_HEIGHT) ==
                     cnn_pkg::IMAGE_HEIGHT - 1);

    always @(negedge clk) begin
        if (pop_pending && expected_q.size() > 0) begin
            void'(expected_q.pop_front());
        end
        pop_pending = pixel_valid;
        head_valid  = (expected_q.size() > 0);
        if (head_valid) begin
            expected_head = expected_q[0];
        end
        if (row_closed) begin
            pix_in_row = 0;
        end
        if (pixel_valid) begin
            pix_in_row = pix_in_row + 1;
        end
        row_closed = row_done;
        if (row_done) begin
            done_total = done_total + 1;
        end
    end

    a_quiet_in_reset : assert property (
        @(posedge clk) (!resetn || !$past(resetn)) |-> (!pixel_valid && !row_done)
    ) else begin
        assert_count = assert_count + 1;
        $display("output strobe was active during or right after reset at %0t", $time);
    end

    a_pixel_expected : assert property (
        @(posedge clk) disable iff (!resetn)
        pixel_valid |-> head_valid
    ) else begin
        assert_count = assert_count + 1;
        $display("a pixel came out with no expected value left at %0t", $time);
    end

    a_pixel_matches : assert property (
        @(posedge clk) disable iff (!resetn)
        (pixel_valid && head_valid) |-> (pixel == expected_head)
    ) else begin
        error_count = error_count + 1;
        $display("Fail %0t: pixel expected %0d, got %0d",
                 $time, $sampled(expected_head), $sampled(pixel));
    end

    a_row_length : assert property (
        @(posedge clk) disable iff (!resetn)
        row_done |-> (pixel_valid && pix_in_row == cnn_pkg::ROW_WIDTH)
    ) else begin
        assert_count = assert_count + 1;
        $display("row_done_o at %0t did not close a row of %0d pixels", $time,
                 cnn_pkg::ROW_WIDTH);
    end

    a_first_pixel_latency : assert property (
        @(posedge clk) disable iff (!resetn)
        (pixel_valid && !$past(pixel_valid)) == $past(launch, 3)
    ) else begin
        assert_count = assert_count + 1;
        $display("first pixel of a row was not three cycles after its trigger at %0t", $time);
    end

    initial begin
        int limit;
        limit       = 3 * cnn_pkg::IMAGE_HEIGHT * (cnn_pkg::ROW_WIDTH + 6) + 16 + 200;
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("the run did not finish within %0d cycles", limit);
        $display("errors: %0d, assertion failures: %0d", error_count, assert_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        row_valid     = 1'b0;
        row_data      = '0;
        row_index     = 0;
        lfsr_state    = 16'd62607;
        expected_head = '0;
        head_valid    = 1'b0;
        pop_pending   = 1'b0;
        row_closed    = 1'b0;
        pix_in_row    = 0;
        done_total    = 0;
        error_count   = 0;
        assert_count  = 0;
        @(posedge resetn);
        repeat (2) begin
            @(negedge clk);
        end
        for (int f = 0; f < 3; f++) begin
            fill_frame(f);   // random, then all 255, then all 0.
            queue_expected();
            send_row(0);
            send_row(1);
            for (int r = 2; r < cnn_pkg::IMAGE_HEIGHT; r++) begin
                wait_row_done();
                @(negedge clk);
                send_row(r);
            end
            wait_row_done();
            wait_row_done();   // the bottom padding row.
            repeat (2) begin
                @(negedge clk);
            end
            a_frame_rows : assert (done_total == (f + 1) * cnn_pkg::IMAGE_HEIGHT) else begin
                assert_count = assert_count + 1;
                $display("frame %0d ended after %0d row_done_o pulses in total", f, done_total);
            end
            a_frame_pixels : assert (expected_q.size() == 0) else begin
                assert_count = assert_count + 1;
                $display("frame %0d left %0d expected pixels unseen", f, expected_q.size());
            end
        end
        $display("errors: %0d, assertion failures: %0d", error_count, assert_count);
        if (error_count == 0 && assert_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
